/* accessPkg.sv */
package accessPkg;

	// datapath widths
	localparam int dataW = 32;
	localparam int regNumW = 5;
	localparam int strobeW = 4;

	// access size, store codes follow the DMSel encoding of the core
	typedef logic [2:0] accessSize_t;

	localparam accessSize_t sizeByte = 3'b000;
	localparam accessSize_t sizeHalf = 3'b001;
	localparam accessSize_t sizeWord = 3'b010;
	// unsigned loads only
	localparam accessSize_t sizeByteU = 3'b011;
	localparam accessSize_t sizeHalfU = 3'b100;

	// debug write enable, all byte lanes of the register
	localparam logic [strobeW-1:0] wbEnAll = 4'b1111;

endpackage

/* addrMapPkg.sv */
package addrMapPkg;

	// kseg1 window, unmapped and uncached in the core
	localparam logic [31:0] kseg1Base = 32'ha000_0000;

	// upper half of a device address
	localparam logic [15:0] uncachedTag = 16'h1faf;

	localparam int ramWords = 256;
	localparam int ramIndexW = 8;

	localparam int devRegs = 8;
	localparam int devIndexW = 3;

	// cached view
	typedef struct packed {
		logic [31-ramIndexW-2:0] pad;
		logic [ramIndexW-1:0] index;
		logic [1:0] offset;
	} ramAddr_t;

	// uncached view, tag picks the region
	typedef struct packed {
		logic [15:0] tag;
		logic [15-devIndexW-2:0] pad;
		logic [devIndexW-1:0] index;
		logic [1:0] offset;
	} devAddr_t;

	typedef union packed {
		ramAddr_t ram;
		devAddr_t dev;
	} physAddr_t;

endpackage

/* memIf.sv */
`timescale 1ns/1ps

// capture stage to data stage
interface memReqIf;
	logic valid;
	logic write;
	accessPkg::accessSize_t size;
	addrMapPkg::physAddr_t paddr;
	logic [accessPkg::dataW-1:0] wdata;
	logic [accessPkg::strobeW-1:0] strobe;
	logic [accessPkg::regNumW-1:0] rd;
	logic [accessPkg::dataW-1:0] pc;

	modport source(
		output valid, write, size, paddr, wdata, strobe, rd, pc
	);

	modport sink(
		input valid, write, size, paddr, wdata, strobe, rd, pc
	);
endinterface

// data stage to load alignment, loads only
interface memRespIf;
	logic valid;
	accessPkg::accessSize_t size;
	logic [1:0] byteOffset;
	logic [accessPkg::dataW-1:0] rdata;
	logic [accessPkg::regNumW-1:0] rd;
	logic [accessPkg::dataW-1:0] pc;

	modport source(
		output valid, size, byteOffset, rdata, rd, pc
	);

	modport sink(
		input valid, size, byteOffset, rdata, rd, pc
	);
endinterface

/* memReqCapture.sv */
`timescale 1ns/1ps

module memReqCapture (
	input  logic clk,
	input  logic rstN,
	input  logic reqValid,
	input  logic reqWrite,
	input  logic squash,
	input  accessPkg::accessSize_t reqSize,
	input  logic [accessPkg::dataW-1:0] reqAddr,
	input  logic [accessPkg::dataW-1:0] reqWdata,
	input  logic [accessPkg::dataW-1:0] reqPc,
	input  logic [accessPkg::regNumW-1:0] reqRd,
	memReqIf.source req
);

	addrMapPkg::physAddr_t paddrNext;
	logic [accessPkg::strobeW-1:0] strobeNext;

	// virtual to physical, kseg1 only
	assign paddrNext = reqAddr - addrMapPkg::kseg1Base;

	// byte lanes for sb, sh, sw
	always_comb begin
		strobeNext = '0;
		if (reqWrite) begin
			case (reqSize)
				accessPkg::sizeByte: strobeNext = 4'b0001 << paddrNext.ram.offset;
				accessPkg::sizeHalf: strobeNext = paddrNext.ram.offset[1] ? 4'b1100 : 4'b0011;
				accessPkg::sizeWord: strobeNext = 4'b1111;
				default:             strobeNext = '0;
			endcase
		end
	end

	// squashed requests never leave this stage
	always_ff @(posedge clk) begin
		if (!rstN) begin
			req.valid <= 1'b0;
		end else begin
			req.valid <= reqValid && !squash;
		end
	end

	always_ff @(posedge clk) begin
		if (reqValid) begin
			req.write <= reqWrite;
			req.size <= reqSize;
			req.paddr <= paddrNext;
			req.wdata <= reqWdata;
			req.strobe <= strobeNext;
			req.rd <= reqRd;
			req.pc <= reqPc;
		end
	end

endmodule

/* dataAccess.sv */
`timescale 1ns/1ps

module dataAccess (
	input  logic clk,
	input  logic rstN,
	memReqIf.sink req,
	memRespIf.source resp
);

	logic [accessPkg::dataW-1:0] ram [addrMapPkg::ramWords];
	logic [accessPkg::dataW-1:0] devReg [addrMapPkg::devRegs];

	logic isUncached;
	logic ramWe;
	logic devWe;
	logic loadEn;
	logic [addrMapPkg::ramIndexW-1:0] ramIdx;
	logic [addrMapPkg::devIndexW-1:0] devIdx;

	// replace only the strobed byte lanes
	function automatic logic [accessPkg::dataW-1:0] mergeLanes(
		input logic [accessPkg::dataW-1:0] oldWord,
		input logic [accessPkg::dataW-1:0] newWord,
		input logic [accessPkg::strobeW-1:0] strobe
	);
		logic [accessPkg::dataW-1:0] merged;
		merged = oldWord;
		for (int i = 0; i < accessPkg::strobeW; i++) begin
			if (strobe[i]) begin
				merged[8*i +: 8] = newWord[8*i +: 8];
			end
		end
		return merged;
	endfunction

	// region select, 1 means device bank
	assign isUncached = (req.paddr.dev.tag == addrMapPkg::uncachedTag);
	assign ramIdx = req.paddr.ram.index;
	assign devIdx = req.paddr.dev.index;

	assign ramWe = req.valid && req.write && !isUncached;
	assign devWe = req.valid && req.write && isUncached;
	assign loadEn = req.valid && !req.write;

	always_ff @(posedge clk) begin
		if (ramWe) begin
			ram[ramIdx] <= mergeLanes(ram[ramIdx], req.wdata, req.strobe);
		end
	end

	// device registers read zero until written
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < addrMapPkg::devRegs; i++) begin
				devReg[i] <= '0;
			end
		end else if (devWe) begin
			devReg[devIdx] <= mergeLanes(devReg[devIdx], req.wdata, req.strobe);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			resp.valid <= 1'b0;
		end else begin
			resp.valid <= loadEn;
		end
	end

	// read word plus what the aligner needs
	always_ff @(posedge clk) begin
		if (loadEn) begin
			resp.rdata <= isUncached ? devReg[devIdx] : ram[ramIdx];
			resp.size <= req.size;
			resp.byteOffset <= req.paddr.ram.offset;
			resp.rd <= req.rd;
			resp.pc <= req.pc;
		end
	end

endmodule

/* loadAlign.sv */
`timescale 1ns/1ps

module loadAlign (
	input  logic clk,
	input  logic rstN,
	memRespIf.sink resp,
	output logic [accessPkg::dataW-1:0] debugWbPc,
	output logic [accessPkg::strobeW-1:0] debugWbRfWen,
	output logic [accessPkg::regNumW-1:0] debugWbRfWnum,
	output logic [accessPkg::dataW-1:0] debugWbRfWdata
);

	logic [7:0] byteSel;
	logic [15:0] halfSel;
	logic [accessPkg::dataW-1:0] loadData;

	assign byteSel = resp.rdata[8*resp.byteOffset +: 8];
	assign halfSel = resp.byteOffset[1] ? resp.rdata[31:16] : resp.rdata[15:0];

	// lb, lbu, lh, lhu, lw
	always_comb begin
		case (resp.size)
			accessPkg::sizeByte:  loadData = {{24{byteSel[7]}}, byteSel};
			accessPkg::sizeByteU: loadData = {24'b0, byteSel};
			accessPkg::sizeHalf:  loadData = {{16{halfSel[15]}}, halfSel};
			accessPkg::sizeHalfU: loadData = {16'b0, halfSel};
			default:              loadData = resp.rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			debugWbRfWen <= '0;
		end else begin
			debugWbRfWen <= resp.valid ? accessPkg::wbEnAll : '0;
		end
	end

	// write-back payload, held between loads
	always_ff @(posedge clk) begin
		if (resp.valid) begin
			debugWbRfWdata <= loadData;
			debugWbRfWnum <= resp.rd;
			debugWbPc <= resp.pc;
		end
	end

endmodule

/* memStage.sv */
`timescale 1ns/1ps

module memStage (
	input  logic clk,
	input  logic rstN,
	input  logic reqValid,
	input  logic reqWrite,
	input  accessPkg::accessSize_t reqSize,
	input  logic [accessPkg::dataW-1:0] reqAddr,
	input  logic [accessPkg::dataW-1:0] reqWdata,
	input  logic [accessPkg::regNumW-1:0] reqRd,
	input  logic [accessPkg::dataW-1:0] reqPc,
	input  logic squash,
	output logic [accessPkg::dataW-1:0] debugWbPc,
	output logic [accessPkg::strobeW-1:0] debugWbRfWen,
	output logic [accessPkg::regNumW-1:0] debugWbRfWnum,
	output logic [accessPkg::dataW-1:0] debugWbRfWdata
);

	memReqIf reqBus();
	memRespIf respBus();

	memReqCapture uReqCapture (
		.clk(clk), .rstN(rstN),
		.reqValid(reqValid), .reqWrite(reqWrite), .squash(squash),
		.reqSize(reqSize), .reqAddr(reqAddr), .reqWdata(reqWdata),
		.reqPc(reqPc), .reqRd(reqRd),
		.req(reqBus.source)
	);

	dataAccess uDataAccess (
		.clk(clk), .rstN(rstN),
		.req(reqBus.sink),
		.resp(respBus.source)
	);

	loadAlign uLoadAlign (
		.clk(clk), .rstN(rstN),
		.resp(respBus.sink),
		.debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
	);

endmodule

/* memStage_properties.sv */
`timescale 1ns/1ps

module memStageProperties (
	input logic clk,
	input logic rstN,
	input logic reqValid,
	input logic reqWrite,
	input logic squash,
	input logic [accessPkg::strobeW-1:0] debugWbRfWen
);

	enLegal: assert property (@(posedge clk) disable iff (!rstN)
		(debugWbRfWen == '0) || (debugWbRfWen == accessPkg::wbEnAll))
		else $error("write enable is neither zero nor all lanes");

	// pipeline is empty right after reset
	enQuietAfterReset: assert property (@(posedge clk)
		$rose(rstN) |-> (debugWbRfWen == '0) ##1 (debugWbRfWen == '0) ##1 (debugWbRfWen == '0))
		else $error("write enable set in the first cycles after reset");

	squashNoWb: assert property (@(posedge clk) disable iff (!rstN)
		(reqValid && squash) |-> ##3 (debugWbRfWen == '0))
		else $error("squashed request produced a write-back");

	storeNoWb: assert property (@(posedge clk) disable iff (!rstN)
		(reqValid && reqWrite) |-> ##3 (debugWbRfWen == '0))
		else $error("store produced a write-back");

endmodule

bind memStage memStageProperties uProperties (
	.clk(clk),
	.rstN(rstN),
	.reqValid(reqValid),
	.reqWrite(reqWrite),
	.squash(squash),
	.debugWbRfWen(debugWbRfWen)
);

/* memStageTb.sv */
`timescale 1ns/1ps

module memStageTb;

	localparam int clkPeriod = 40;
	localparam int resetCycles = 5;
	localparam int timeoutMargin = 20;
	localparam string inputFile = "memStage_input.txt";

	// one line of the stimulus file
	typedef struct packed {
		logic [31:0] gap;
		logic write;
		accessPkg::accessSize_t size;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [4:0] rd;
		logic [31:0] pc;
		logic squash;
		logic [31:0] expData;
	} access_t;

	typedef struct packed {
		logic [4:0] rd;
		logic [31:0] pc;
		logic [31:0] data;
	} wbExp_t;

	logic clk;
	logic rstN;
	logic reqValid;
	logic reqWrite;
	accessPkg::accessSize_t reqSize;
	logic [31:0] reqAddr;
	logic [31:0] reqWdata;
	logic [4:0] reqRd;
	logic [31:0] reqPc;
	logic squash;
	logic [31:0] debugWbPc;
	logic [3:0] debugWbRfWen;
	logic [4:0] debugWbRfWnum;
	logic [31:0] debugWbRfWdata;

	access_t accesses[$];
	wbExp_t expQ[$];
	int totalGap = 0;
	int cycleLimit = 0;
	int cycleCount = 0;
	bit failShown = 1'b0;
	bit runDone = 1'b0;

	memStage DUT (
		.clk(clk), .rstN(rstN),
		.reqValid(reqValid), .reqWrite(reqWrite), .reqSize(reqSize),
		.reqAddr(reqAddr), .reqWdata(reqWdata), .reqRd(reqRd), .reqPc(reqPc),
		.squash(squash),
		.debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic abortRun();
		failShown = 1'b1;
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compareWord(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		assert (actual === expected) else begin
			$display("** Error at %t: %s = %h, expected %h", $time, name, actual, expected);
			abortRun();
		end
	endtask

	task automatic readStimulus();
		int fd;
		int n;
		string line;
		access_t a;
		logic [31:0] vGap, vWrite, vSize, vAddr, vWdata, vRd, vPc, vSquash, vExp;
		fd = $fopen(inputFile, "r");
		if (fd == 0) begin
			$display("could not open the stimulus file %s", inputFile);
			abortRun();
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// skip blank and comment lines
				if (line.len() >= 2 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", vGap, vWrite, vSize,
						vAddr, vWdata, vRd, vPc, vSquash, vExp);
					if (n != 9) begin
						$display("malformed line in %s: %s", inputFile, line);
						abortRun();
					end else begin
						a.gap = vGap;
						a.write = vWrite[0];
						a.size = vSize[2:0];
						a.addr = vAddr;
						a.wdata = vWdata;
						a.rd = vRd[4:0];
						a.pc = vPc;
						a.squash = vSquash[0];
						a.expData = vExp;
						accesses.push_back(a);
						totalGap += int'(a.gap);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic driveAccess(input access_t a);
		wbExp_t e;
		reqValid <= 1'b1;
		reqWrite <= a.write;
		reqSize <= a.size;
		reqAddr <= a.addr;
		reqWdata <= a.wdata;
		reqRd <= a.rd;
		reqPc <= a.pc;
		squash <= a.squash;
		// only live loads come back on the debug port
		if (!a.write && !a.squash) begin
			e.rd = a.rd;
			e.pc = a.pc;
			e.data = a.expData;
			expQ.push_back(e);
		end
	endtask

	task automatic checkWriteBack();
		wbExp_t e;
		assert (expQ.size() > 0) else begin
			$display("write-back at %t while no load was pending", $time);
			abortRun();
		end
		e = expQ.pop_front();
		// a write-back enables all four byte lanes
		compareWord("debugWbRfWen", {28'b0, debugWbRfWen}, 32'h0000_000f);
		compareWord("debugWbRfWnum", {27'b0, debugWbRfWnum}, {27'b0, e.rd});
		compareWord("debugWbPc", debugWbPc, e.pc);
		compareWord("debugWbRfWdata", debugWbRfWdata, e.data);
	endtask

	// outputs settle after the rising edge
	always @(negedge clk) begin
		if (rstN && debugWbRfWen != '0) begin
			checkWriteBack();
		end
	end

	always @(posedge clk) begin
		if (rstN) begin
			cycleCount <= cycleCount + 1;
			if (cycleCount >= cycleLimit) begin
				$display("timeout after %0d cycles, %0d expected write-backs never arrived",
					cycleCount, expQ.size());
				abortRun();
			end
		end
	end

	initial begin
		$timeformat(-9, 0, " ns", 0);
		rstN = 1'b0;
		reqValid = 1'b0;
		reqWrite = 1'b0;
		reqSize = accessPkg::sizeWord;
		reqAddr = '0;
		reqWdata = '0;
		reqRd = '0;
		reqPc = '0;
		squash = 1'b0;
		readStimulus();
		cycleLimit = accesses.size() + totalGap + timeoutMargin;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		for (int i = 0; i < accesses.size(); i++) begin
			repeat (accesses[i].gap) begin
				@(posedge clk);
				reqValid <= 1'b0;
			end
			@(posedge clk);
			driveAccess(accesses[i]);
		end
		@(posedge clk);
		reqValid <= 1'b0;
		squash <= 1'b0;
		// fixed write-back latency, then drain
		repeat (4) @(posedge clk);
		while (expQ.size() != 0) @(posedge clk);
		runDone = 1'b1;
		$display("Done: no errors");
		$finish;
	end

	// run ended by a failing property
	final begin
		if (!runDone && !failShown) begin
			$display("Done: errors found");
		end
	end

endmodule

/* memStage.f */
accessPkg.sv
addrMapPkg.sv
memIf.sv
memReqCapture.sv
dataAccess.sv
loadAlign.sv
memStage.sv
memStage_properties.sv
memStageTb.sv

/* memStage_input.txt */
# gap write size addr wdata rd pc squash expData, all hex, gap is idle cycles before
# size 0 byte, 1 half, 2 word, 3 byte unsigned, 4 half unsigned
0 1 2 a0000100 12345678 00 bfc00000 0 00000000
1 0 2 a0000100 00000000 03 bfc00004 0 12345678
2 1 2 a0000104 11223344 00 bfc00008 0 00000000
0 1 0 a0000105 aaaaaaaa 00 bfc0000c 0 00000000
0 1 1 a0000106 beefbeef 00 bfc00010 0 00000000
1 0 2 a0000104 00000000 04 bfc00014 0 beefaa44
0 0 0 a0000104 00000000 05 bfc00018 0 00000044
0 0 0 a0000105 00000000 06 bfc0001c 0 ffffffaa
0 0 0 a0000106 00000000 07 bfc00020 0 ffffffef
0 0 0 a0000107 00000000 08 bfc00024 0 ffffffbe
1 0 3 a0000104 00000000 09 bfc00028 0 00000044
0 0 3 a0000105 00000000 0a bfc0002c 0 000000aa
0 0 3 a0000106 00000000 0b bfc00030 0 000000ef
0 0 3 a0000107 00000000 0c bfc00034 0 000000be
1 0 1 a0000104 00000000 0d bfc00038 0 ffffaa44
0 0 1 a0000106 00000000 0e bfc0003c 0 ffffbeef
0 0 4 a0000104 00000000 0f bfc00040 0 0000aa44
0 0 4 a0000106 00000000 10 bfc00044 0 0000beef
2 0 2 bfaf0008 00000000 11 bfc00048 0 00000000
0 1 2 a0000008 cafef00d 00 bfc0004c 0 00000000
0 1 2 bfaf0008 5a5a0001 00 bfc00050 0 00000000
1 0 2 bfaf0008 00000000 12 bfc00054 0 5a5a0001
0 0 2 a0000008 00000000 13 bfc00058 0 cafef00d
2 1 2 a0000100 deadbeef 00 bfc0005c 1 00000000
0 0 2 a0000100 00000000 14 bfc00060 0 12345678
0 0 2 a0000100 00000000 15 bfc00064 1 00000000
2 1 2 a000010c 0f0e0d0c 00 bfc00068 0 00000000
0 0 2 a000010c 00000000 16 bfc0006c 0 0f0e0d0c

/* run.sh */
#!/usr/bin/env bash
# build memStageTb with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module memStageTb -f memStage.f -o memStageSim \
	&& { ./obj_dir/memStageSim > sim.log 2>&1 || true; } \
	&& cat sim.log \
	&& grep -qx "Done: no errors" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
